//--- hw/rdma_resp_pkg.sv
package rdma_resp_pkg;

	// network opcodes carried by a descriptor
	// read response codes follow the ib transport encoding
	typedef enum logic [4:0] {
		rd_resp_first  = 5'h0d,
		rd_resp_middle = 5'h0e,
		rd_resp_last   = 5'h0f,
		rd_resp_only   = 5'h10,
		// internal codes for locally generated work
		gen_cqe        = 5'h1c,
		gen_event      = 5'h1d
	} net_opcode_e;

	// verbs level opcode, copied into the cqe
	typedef logic [4:0] verbs_opcode_t;

	// descriptor metadata, msb first
	// reserved bits pad the opcodes to byte lanes
	typedef struct packed {
		logic [15:0]   pkt_start_slot;
		logic [31:0]   wqe_addr;
		logic [15:0]   dlid;
		logic [15:0]   pkt_length;
		logic [31:0]   msg_length;
		logic [2:0]    rsvd_1;
		net_opcode_e   net_opcode;
		logic [23:0]   remote_qpn;
		logic [2:0]    rsvd_0;
		verbs_opcode_t verbs_opcode;
		logic [23:0]   local_qpn;
	} pkt_meta_t;

	// memory region translation, at most two physical pages
	typedef struct packed {
		logic [3:0]  state;
		logic        page_valid_0;
		logic        page_valid_1;
		logic [31:0] page_size_0;
		logic [31:0] page_size_1;
		logic [63:0] phy_addr_0;
		logic [63:0] phy_addr_1;
	} mr_resp_t;

	typedef enum logic [1:0] {disp_idle, disp_judge, disp_busy} dispatch_state_e;

endpackage

//--- hw/rdma_dma_pkg.sv
package rdma_dma_pkg;

	// packet buffer slot is 64 bytes
	localparam int slot_bytes_log = 6;

	// cqe size in bytes
	localparam logic [15:0] cqe_length = 16'd32;

	// owner byte when hardware hands the entry over
	localparam logic [7:0] cq_owner_hw = 8'h80;

	// one scatter dma request
	typedef struct packed {
		logic [15:0] req_length;
		logic [31:0] page_size;
		logic [63:0] phy_addr;
	} scatter_req_t;

	// completion queue entry, 256 bits, msb first
	typedef struct packed {
		logic [7:0]  owner;
		logic [7:0]  rsvd;
		logic [7:0]  is_send;
		logic [7:0]  opcode;
		logic [31:0] wqe_addr;
		logic [31:0] byte_cnt;
		logic [31:0] imm_pkey;
		logic [15:0] rlid;
		logic [7:0]  g_mlpath;
		logic [7:0]  sl_ipok;
		logic [31:0] rqpn;
		logic [31:0] ee;
		logic [31:0] my_qpn;
	} cqe_t;

	// packet buffer release request
	typedef struct packed {
		logic [15:0] slot_count;
		logic [15:0] start_slot;
	} delete_req_t;

	typedef enum logic [1:0] {ps_fetch, ps_page0, ps_page1, ps_data} payload_state_e;

endpackage

//--- hw/resp_dispatch.sv
`timescale 1ns/1ps

module resp_dispatch
	import rdma_resp_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      fetch_valid,
	input  pkt_meta_t fetch_meta,
	input  mr_resp_t  fetch_mr,
	input  logic      payload_done,
	input  logic      cqe_done,
	output logic      fetch_ready,
	output logic      payload_start,
	output logic      cqe_start,
	output pkt_meta_t meta,
	output mr_resp_t  mr
);

	dispatch_state_e state;
	logic            is_read_resp;
	logic            is_cqe;

	// only one job in flight, so accept only when idle
	assign fetch_ready = (state == disp_idle);

	// descriptor capture on the accept edge
	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready) begin
			meta <= fetch_meta;
			mr   <= fetch_mr;
		end
	end

	// opcode decode from the held descriptor
	always_comb begin
		is_read_resp = 1'b0;
		is_cqe       = 1'b0;
		case (meta.net_opcode)
			rd_resp_first,
			rd_resp_middle,
			rd_resp_last,
			rd_resp_only: is_read_resp = 1'b1;
			gen_cqe:      is_cqe = 1'b1;
			// gen_event and anything unknown fall through
			default:      is_cqe = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= disp_idle;
			payload_start <= 1'b0;
			cqe_start     <= 1'b0;
		end else begin
			// start strobes last one cycle
			payload_start <= 1'b0;
			cqe_start     <= 1'b0;
			case (state)
				disp_idle: begin
					if (fetch_valid) begin
						state <= disp_judge;
					end
				end
				disp_judge: begin
					if (is_read_resp) begin
						payload_start <= 1'b1;
						state         <= disp_busy;
					end else if (is_cqe) begin
						cqe_start <= 1'b1;
						state     <= disp_busy;
					end else begin
						// descriptor consumed, nothing written
						state <= disp_idle;
					end
				end
				disp_busy: begin
					// wait for the running engine to finish
					if (payload_done || cqe_done) begin
						state <= disp_idle;
					end
				end
				default: state <= disp_idle;
			endcase
		end
	end

endmodule

//--- hw/payload_scatter.sv
`timescale 1ns/1ps

module payload_scatter
	import rdma_resp_pkg::*;
	import rdma_dma_pkg::*;
#(
	parameter int data_width = 256
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  pkt_meta_t             meta,
	input  mr_resp_t              mr,
	input  logic                  delete_req_ready,
	input  logic                  delete_resp_valid,
	input  logic                  delete_resp_last,
	input  logic [data_width-1:0] delete_resp_data,
	input  logic                  req_ready,
	input  logic                  data_ready,
	output logic                  delete_req_valid,
	output delete_req_t           delete_req_head,
	output logic                  delete_resp_ready,
	output logic                  req_valid,
	output scatter_req_t          req,
	output logic                  data_valid,
	output logic [data_width-1:0] data,
	output logic                  done
);

	payload_state_e state;
	logic           busy;
	logic [15:0]    slot_count;
	logic           slot_partial;

	// slots covering the packet, last one may be partly used
	assign slot_partial = |meta.pkt_length[slot_bytes_log-1:0];
	assign slot_count   = (meta.pkt_length >> slot_bytes_log) + {15'd0, slot_partial};

	// release request, meta is held so the head stays stable
	assign delete_req_valid = busy && (state == ps_fetch);
	assign delete_req_head  = {slot_count, meta.pkt_start_slot};

	// one request per translated page
	assign req_valid = busy && ((state == ps_page0) || (state == ps_page1));
	always_comb begin
		req.req_length = meta.pkt_length;
		if (state == ps_page1) begin
			req.page_size = mr.page_size_1;
			req.phy_addr  = mr.phy_addr_1;
		end else begin
			req.page_size = mr.page_size_0;
			req.phy_addr  = mr.phy_addr_0;
		end
	end

	// payload beats pass through under fifo back-pressure
	assign data_valid        = busy && (state == ps_data) && delete_resp_valid;
	assign data              = delete_resp_data;
	assign delete_resp_ready = busy && (state == ps_data) && data_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy  <= 1'b0;
			state <= ps_fetch;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				state <= ps_fetch;
			end else if (busy) begin
				case (state)
					ps_fetch: begin
						if (delete_req_ready) begin
							state <= ps_page0;
						end
					end
					ps_page0: begin
						// second page only when the region spans it
						if (req_ready) begin
							state <= mr.page_valid_1 ? ps_page1 : ps_data;
						end
					end
					ps_page1: begin
						if (req_ready) begin
							state <= ps_data;
						end
					end
					ps_data: begin
						// job ends once the last beat is taken
						if (delete_resp_valid && data_ready && delete_resp_last) begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= ps_fetch;
						end
					end
					default: state <= ps_fetch;
				endcase
			end
		end
	end

endmodule

//--- hw/cqe_writer.sv
`timescale 1ns/1ps

module cqe_writer
	import rdma_resp_pkg::*;
	import rdma_dma_pkg::*;
#(
	parameter int data_width = 256
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  pkt_meta_t             meta,
	input  mr_resp_t              mr,
	input  logic                  ready,
	output logic                  valid,
	output scatter_req_t          req,
	output logic [data_width-1:0] entry,
	output logic                  done
);

	cqe_t        cqe_q;
	logic [63:0] addr_q;

	// entry fields latched on start
	always_ff @(posedge clk) begin
		if (start) begin
			cqe_q.owner    <= cq_owner_hw;
			cqe_q.rsvd     <= 8'd0;
			cqe_q.is_send  <= 8'd1;
			cqe_q.opcode   <= 8'(meta.verbs_opcode);
			cqe_q.wqe_addr <= meta.wqe_addr;
			cqe_q.byte_cnt <= meta.msg_length;
			cqe_q.imm_pkey <= 32'd0;
			cqe_q.rlid     <= meta.dlid;
			cqe_q.g_mlpath <= 8'd0;
			cqe_q.sl_ipok  <= 8'd0;
			cqe_q.rqpn     <= 32'(meta.remote_qpn);
			cqe_q.ee       <= 32'd0;
			cqe_q.my_qpn   <= 32'(meta.local_qpn);
			// cq ring slot comes from page 0 of the translation
			addr_q         <= mr.phy_addr_0;
		end
	end

	// single request covering exactly one entry
	assign req   = {cqe_length, 32'(cqe_length), addr_q};
	assign entry = data_width'(cqe_q);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				valid <= 1'b1;
			end else if (valid && ready) begin
				valid <= 1'b0;
				done  <= 1'b1;
			end
		end
	end

endmodule

//--- hw/scatter_arbiter.sv
`timescale 1ns/1ps

module scatter_arbiter
	import rdma_dma_pkg::*;
#(
	parameter int data_width = 256
)
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pay_req_valid,
	input  scatter_req_t          pay_req,
	input  logic                  pay_data_valid,
	input  logic [data_width-1:0] pay_data,
	input  logic                  cqe_valid,
	input  scatter_req_t          cqe_req,
	input  logic [data_width-1:0] cqe_entry,
	input  logic                  scatter_req_prog_full,
	input  logic                  scatter_data_prog_full,
	output logic                  pay_req_ready,
	output logic                  pay_data_ready,
	output logic                  cqe_ready,
	output logic                  scatter_req_wen,
	output scatter_req_t          scatter_req_din,
	output logic                  scatter_data_wen,
	output logic [data_width-1:0] scatter_data_din
);

	logic pay_req_take;
	logic pay_data_take;
	logic cqe_take;

	// each fifo gates only its own payload stream
	assign pay_req_ready  = !scatter_req_prog_full;
	assign pay_data_ready = !scatter_data_prog_full;

	// cqe pair goes as one, needs room in both fifos
	// payload offers win the cycle
	assign cqe_ready = !scatter_req_prog_full && !scatter_data_prog_full
		&& !pay_req_valid && !pay_data_valid;

	assign pay_req_take  = pay_req_valid && pay_req_ready;
	assign pay_data_take = pay_data_valid && pay_data_ready;
	assign cqe_take      = cqe_valid && cqe_ready;

	// write strobes one cycle after the grant
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			scatter_req_wen  <= 1'b0;
			scatter_data_wen <= 1'b0;
		end else begin
			scatter_req_wen  <= pay_req_take || cqe_take;
			scatter_data_wen <= pay_data_take || cqe_take;
		end
	end

	// write data follows the winning source
	always_ff @(posedge clk) begin
		if (pay_req_take) begin
			scatter_req_din <= pay_req;
		end else if (cqe_take) begin
			scatter_req_din <= cqe_req;
		end
		if (pay_data_take) begin
			scatter_data_din <= pay_data;
		end else if (cqe_take) begin
			scatter_data_din <= cqe_entry;
		end
	end

endmodule

//--- hw/resp_scatter_engine.sv
`timescale 1ns/1ps

module resp_scatter_engine
	import rdma_resp_pkg::*;
	import rdma_dma_pkg::*;
#(
	parameter int data_width = 256
)
(
	input  logic                  clk,
	input  logic                  rst,
	// descriptor from the ooo station
	input  logic                  fetch_valid,
	input  pkt_meta_t             fetch_meta,
	input  mr_resp_t              fetch_mr,
	output logic                  fetch_ready,
	// scatter fifos
	output logic                  scatter_req_wen,
	output scatter_req_t          scatter_req_din,
	input  logic                  scatter_req_prog_full,
	output logic                  scatter_data_wen,
	output logic [data_width-1:0] scatter_data_din,
	input  logic                  scatter_data_prog_full,
	// packet buffer
	output logic                  delete_req_valid,
	output delete_req_t           delete_req_head,
	input  logic                  delete_req_ready,
	input  logic                  delete_resp_valid,
	input  logic                  delete_resp_last,
	input  logic [data_width-1:0] delete_resp_data,
	output logic                  delete_resp_ready
);

	// dispatcher to engines
	logic      payload_start;
	logic      cqe_start;
	logic      payload_done;
	logic      cqe_done;
	pkt_meta_t meta;
	mr_resp_t  mr;

	// engines to arbiter
	logic                  pay_req_valid;
	logic                  pay_req_ready;
	scatter_req_t          pay_req;
	logic                  pay_data_valid;
	logic                  pay_data_ready;
	logic [data_width-1:0] pay_data;
	logic                  cqe_valid;
	logic                  cqe_ready;
	scatter_req_t          cqe_req;
	logic [data_width-1:0] cqe_entry;

	resp_dispatch u_dispatch (
		.clk          (clk),
		.rst          (rst),
		.fetch_valid  (fetch_valid),
		.fetch_meta   (fetch_meta),
		.fetch_mr     (fetch_mr),
		.payload_done (payload_done),
		.cqe_done     (cqe_done),
		.fetch_ready  (fetch_ready),
		.payload_start(payload_start),
		.cqe_start    (cqe_start),
		.meta         (meta),
		.mr           (mr)
	);

	payload_scatter #(.data_width(data_width)) u_payload (
		.clk              (clk),
		.rst              (rst),
		.start            (payload_start),
		.meta             (meta),
		.mr               (mr),
		.delete_req_ready (delete_req_ready),
		.delete_resp_valid(delete_resp_valid),
		.delete_resp_last (delete_resp_last),
		.delete_resp_data (delete_resp_data),
		.req_ready        (pay_req_ready),
		.data_ready       (pay_data_ready),
		.delete_req_valid (delete_req_valid),
		.delete_req_head  (delete_req_head),
		.delete_resp_ready(delete_resp_ready),
		.req_valid        (pay_req_valid),
		.req              (pay_req),
		.data_valid       (pay_data_valid),
		.data             (pay_data),
		.done             (payload_done)
	);

	cqe_writer #(.data_width(data_width)) u_cqe (
		.clk  (clk),
		.rst  (rst),
		.start(cqe_start),
		.meta (meta),
		.mr   (mr),
		.ready(cqe_ready),
		.valid(cqe_valid),
		.req  (cqe_req),
		.entry(cqe_entry),
		.done (cqe_done)
	);

	scatter_arbiter #(.data_width(data_width)) u_arbiter (
		.clk                   (clk),
		.rst                   (rst),
		.pay_req_valid         (pay_req_valid),
		.pay_req               (pay_req),
		.pay_data_valid        (pay_data_valid),
		.pay_data              (pay_data),
		.cqe_valid             (cqe_valid),
		.cqe_req               (cqe_req),
		.cqe_entry             (cqe_entry),
		.scatter_req_prog_full (scatter_req_prog_full),
		.scatter_data_prog_full(scatter_data_prog_full),
		.pay_req_ready         (pay_req_ready),
		.pay_data_ready        (pay_data_ready),
		.cqe_ready             (cqe_ready),
		.scatter_req_wen       (scatter_req_wen),
		.scatter_req_din       (scatter_req_din),
		.scatter_data_wen      (scatter_data_wen),
		.scatter_data_din      (scatter_data_din)
	);

endmodule

//--- verif/resp_scatter_properties.sv
`timescale 1ns/1ps

module resp_scatter_properties
	import rdma_dma_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input logic        fetch_ready,
	input logic        scatter_req_wen,
	input logic        scatter_req_prog_full,
	input logic        scatter_data_wen,
	input logic        scatter_data_prog_full,
	input logic        delete_req_valid,
	input logic        delete_req_ready,
	input delete_req_t delete_req_head,
	input logic        delete_resp_ready
);

	// number of failed assertions
	int fail_count = 0;

	// outputs quiet while in reset
	a_reset_quiet: assert property (@(posedge clk)
		rst |-> !scatter_req_wen && !scatter_data_wen && !delete_req_valid)
		else begin
			fail_count++;
			$error("write or delete active during reset");
		end

	// full fifo blocks the following write
	a_req_full: assert property (@(posedge clk) disable iff (rst)
		scatter_req_prog_full |=> !scatter_req_wen)
		else begin
			fail_count++;
			$error("request write after prog_full");
		end

	a_data_full: assert property (@(posedge clk) disable iff (rst)
		scatter_data_prog_full |=> !scatter_data_wen)
		else begin
			fail_count++;
			$error("data write after prog_full");
		end

	// no new descriptor while a payload job runs
	a_busy_no_fetch: assert property (@(posedge clk) disable iff (rst)
		(delete_req_valid || delete_resp_ready) |-> !fetch_ready)
		else begin
			fail_count++;
			$error("fetch_ready high during a payload job");
		end

	a_head_stable: assert property (@(posedge clk) disable iff (rst)
		delete_req_valid && !delete_req_ready |=> $stable(delete_req_head))
		else begin
			fail_count++;
			$error("delete head changed while waiting");
		end

endmodule

bind resp_scatter_engine resp_scatter_properties u_props (
	.clk                   (clk),
	.rst                   (rst),
	.fetch_ready           (fetch_ready),
	.scatter_req_wen       (scatter_req_wen),
	.scatter_req_prog_full (scatter_req_prog_full),
	.scatter_data_wen      (scatter_data_wen),
	.scatter_data_prog_full(scatter_data_prog_full),
	.delete_req_valid      (delete_req_valid),
	.delete_req_ready      (delete_req_ready),
	.delete_req_head       (delete_req_head),
	.delete_resp_ready     (delete_resp_ready)
);

//--- verif/tb_resp_scatter_engine.sv
`timescale 1ns/1ps

module tb_resp_scatter_engine
	import rdma_resp_pkg::*;
	import rdma_dma_pkg::*;
;

	localparam int data_width = 256;
	localparam int wait_limit = 2000;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  fetch_valid;
	pkt_meta_t             fetch_meta;
	mr_resp_t              fetch_mr;
	logic                  fetch_ready;
	logic                  scatter_req_wen;
	scatter_req_t          scatter_req_din;
	logic                  scatter_req_prog_full;
	logic                  scatter_data_wen;
	logic [data_width-1:0] scatter_data_din;
	logic                  scatter_data_prog_full;
	logic                  delete_req_valid;
	delete_req_t           delete_req_head;
	logic                  delete_req_ready;
	logic                  delete_resp_valid;
	logic                  delete_resp_last;
	logic [data_width-1:0] delete_resp_data;
	logic                  delete_resp_ready;

	integer seed = 32'h5ec7_ca35;
	int     errors = 0;
	int     checks = 0;
	bit     timed_out = 1'b0;
	bit     stall_en = 1'b0;
	string  test_name = "reset";

	// expected traffic and the beats held by the packet buffer model
	scatter_req_t          exp_req[$];
	logic [data_width-1:0] exp_data[$];
	delete_req_t           exp_del[$];
	logic [data_width-1:0] pb_beats[$];

	// packet buffer model state
	bit          req_fire;
	bit          resp_fire;
	delete_req_t head_seen;
	int          beats_left = 0;
	logic [31:0] rnd;

	resp_scatter_engine #(.data_width(data_width)) dut (.*);

	always #5 clk = ~clk;

	// expected requests and beats for one descriptor
	function automatic void build_expect(pkt_meta_t m, mr_resp_t r);
		cqe_t        c;
		int          nslots;
		delete_req_t d;
		nslots = (int'(m.pkt_length) + 63) / 64;
		if (m.net_opcode inside {rd_resp_first, rd_resp_middle, rd_resp_last, rd_resp_only}) begin
			d.slot_count = 16'(nslots);
			d.start_slot = m.pkt_start_slot;
			exp_del.push_back(d);
			exp_req.push_back({m.pkt_length, r.page_size_0, r.phy_addr_0});
			if (r.page_valid_1) begin
				exp_req.push_back({m.pkt_length, r.page_size_1, r.phy_addr_1});
			end
			foreach (pb_beats[i]) begin
				exp_data.push_back(pb_beats[i]);
			end
		end else if (m.net_opcode == gen_cqe) begin
			c = '0;
			c.owner    = 8'h80;
			c.is_send  = 8'd1;
			c.opcode   = {3'd0, m.verbs_opcode};
			c.wqe_addr = m.wqe_addr;
			c.byte_cnt = m.msg_length;
			c.rlid     = m.dlid;
			c.rqpn     = {8'd0, m.remote_qpn};
			c.my_qpn   = {8'd0, m.local_qpn};
			exp_req.push_back({16'd32, 32'd32, r.phy_addr_0});
			exp_data.push_back(data_width'(c));
		end
	endfunction

	// random fifo stalls driven just after the edge
	always @(posedge clk) begin
		#1;
		rnd = $random(seed);
		scatter_req_prog_full  <= stall_en && (rnd[1:0] == 2'b00);
		scatter_data_prog_full <= stall_en && (rnd[3:2] == 2'b00);
	end

	// packet buffer model samples handshakes mid-cycle
	always begin
		@(negedge clk);
		req_fire  = delete_req_valid && delete_req_ready;
		resp_fire = delete_resp_valid && delete_resp_ready;
		head_seen = delete_req_head;
		@(posedge clk);
		#1;
		rnd = $random(seed);
		if (req_fire) begin
			checks++;
			if (exp_del.size() == 0) begin
				$display("unexpected delete request in test %s", test_name);
				errors++;
			end else if (exp_del[0] !== head_seen) begin
				$display("** Error %s delete head expected %h actual %h",
					test_name, exp_del[0], head_seen);
				errors++;
				void'(exp_del.pop_front());
			end else begin
				void'(exp_del.pop_front());
			end
			beats_left = int'(head_seen.slot_count);
		end
		if (resp_fire) begin
			void'(pb_beats.pop_front());
			beats_left--;
			delete_resp_valid = 1'b0;
		end
		// a beat once offered is held until taken
		if (!delete_resp_valid && beats_left > 0 && pb_beats.size() > 0 && rnd[4]) begin
			delete_resp_valid = 1'b1;
		end
		if (beats_left <= 0) begin
			delete_resp_valid = 1'b0;
		end
		delete_resp_data = (pb_beats.size() > 0) ? pb_beats[0] : '0;
		delete_resp_last = (beats_left == 1);
		delete_req_ready = rnd[5];
	end

	// compare at mid-cycle where write outputs are stable
	always @(negedge clk) begin
		if (!rst && scatter_req_wen) begin
			checks++;
			if (exp_req.size() == 0) begin
				$display("unexpected request write in test %s", test_name);
				errors++;
			end else begin
				if (exp_req[0] !== scatter_req_din) begin
					$display("** Error %s request expected %h actual %h",
						test_name, exp_req[0], scatter_req_din);
					errors++;
				end
				void'(exp_req.pop_front());
			end
		end
		if (!rst && scatter_data_wen) begin
			checks++;
			if (exp_data.size() == 0) begin
				$display("unexpected data write in test %s", test_name);
				errors++;
			end else begin
				// all requests of the job go out before its first beat
				if (exp_req.size() != 0) begin
					$display("data beat written before its requests in test %s", test_name);
					errors++;
				end
				if (exp_data[0] !== scatter_data_din) begin
					$display("** Error %s data expected %h actual %h",
						test_name, exp_data[0], scatter_data_din);
					errors++;
				end
				void'(exp_data.pop_front());
			end
		end
	end

	task automatic send_desc(pkt_meta_t m, mr_resp_t r);
		int n;
		n = 0;
		fetch_meta  = m;
		fetch_mr    = r;
		fetch_valid = 1'b1;
		while (!fetch_ready && n < wait_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= wait_limit) begin
			$display("timeout: fetch_ready never rose in test %s", test_name);
			timed_out = 1'b1;
			errors++;
		end
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (!(fetch_ready && exp_req.size() == 0 && exp_data.size() == 0
			&& exp_del.size() == 0 && pb_beats.size() == 0) && n < wait_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= wait_limit) begin
			$display("timeout: job did not finish in test %s", test_name);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	// one descriptor end to end
	task automatic run_desc(pkt_meta_t m, mr_resp_t r);
		int nslots;
		if (timed_out) begin
			return;
		end
		if (m.net_opcode inside {rd_resp_first, rd_resp_middle, rd_resp_last, rd_resp_only}) begin
			nslots = (int'(m.pkt_length) + 63) / 64;
			for (int i = 0; i < nslots; i++) begin
				pb_beats.push_back({$random(seed), $random(seed), $random(seed), $random(seed),
					$random(seed), $random(seed), $random(seed), $random(seed)});
			end
		end
		build_expect(m, r);
		send_desc(m, r);
		if (!timed_out) begin
			wait_idle();
		end
		repeat (3) @(posedge clk);
		#1;
	endtask

	function automatic pkt_meta_t rand_meta(net_opcode_e op);
		pkt_meta_t    m;
		logic [191:0] raw;
		raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed),
			$random(seed)};
		m = raw[$bits(pkt_meta_t)-1:0];
		m.net_opcode = op;
		m.pkt_length = {8'd0, m.pkt_length[7:0]} + 16'd1;
		return m;
	endfunction

	function automatic mr_resp_t rand_mr(bit two_pages);
		mr_resp_t     r;
		logic [223:0] raw;
		raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed),
			$random(seed), $random(seed)};
		r = raw[$bits(mr_resp_t)-1:0];
		r.page_valid_1 = two_pages;
		return r;
	endfunction

	initial begin
		pkt_meta_t m;
		mr_resp_t  r;
		logic [31:0] pick;
		rst                    = 1'b1;
		fetch_valid            = 1'b0;
		fetch_meta             = '0;
		fetch_mr               = '0;
		scatter_req_prog_full  = 1'b0;
		scatter_data_prog_full = 1'b0;
		delete_req_ready       = 1'b0;
		delete_resp_valid      = 1'b0;
		delete_resp_last       = 1'b0;
		delete_resp_data       = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		test_name = "single_page";
		m = rand_meta(rd_resp_only);
		m.pkt_length = 16'd200;
		run_desc(m, rand_mr(1'b0));

		test_name = "two_page";
		m = rand_meta(rd_resp_first);
		m.pkt_length = 16'd64;
		run_desc(m, rand_mr(1'b1));

		test_name = "completion";
		run_desc(rand_meta(gen_cqe), rand_mr(1'b0));

		// compare and model flag any write here
		test_name = "gen_event";
		run_desc(rand_meta(gen_event), rand_mr(1'b1));
		test_name = "unknown_opcode";
		m = rand_meta(rd_resp_only);
		m.net_opcode = net_opcode_e'(5'h05);
		run_desc(m, rand_mr(1'b0));

		test_name = "random_stalls";
		stall_en = 1'b1;
		for (int i = 0; i < 40; i++) begin
			pick = $random(seed);
			case (pick[2:0])
				3'd0: m = rand_meta(rd_resp_first);
				3'd1: m = rand_meta(rd_resp_middle);
				3'd2: m = rand_meta(rd_resp_last);
				3'd3: m = rand_meta(gen_cqe);
				3'd4: m = rand_meta(gen_event);
				default: m = rand_meta(rd_resp_only);
			endcase
			r = rand_mr(pick[3]);
			run_desc(m, r);
		end
		stall_en = 1'b0;

		// failed bound assertions count as errors
		errors += dut.u_props.fail_count;

		$display("checks=%0d errors=%0d timed_out=%0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- resp_scatter_engine.f
hw/rdma_resp_pkg.sv
hw/rdma_dma_pkg.sv
hw/resp_dispatch.sv
hw/payload_scatter.sv
hw/cqe_writer.sv
hw/scatter_arbiter.sv
hw/resp_scatter_engine.sv
verif/resp_scatter_properties.sv
verif/tb_resp_scatter_engine.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_resp_scatter_engine
FILELIST  ?= resp_scatter_engine.f
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(wildcard hw/*.sv) $(wildcard verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
